// File: include/uart_link_macros.svh
`ifndef UART_LINK_MACROS_SVH
`define UART_LINK_MACROS_SVH

// fifo address width, depth is 2**LINK_FIFO_AW entries
`define LINK_FIFO_AW 3

// width of one data word on the link
`define LINK_DATA_W 8

// clock cycles spent on each serial bit
`define UART_CLKS_PER_BIT 8

// start bit, eight data bits and one stop bit
`define UART_FRAME_BITS 10

`endif

// File: design/uart_link_pkg.sv
`include "uart_link_macros.svh"

package uart_link_pkg;

  // one data word as it travels through the fifos and the uart
  typedef logic [`LINK_DATA_W-1:0] byte_t;

  // flags a fifo reports back to the host
  typedef struct packed {
    logic full;
    logic half_full;
    logic empty;
  } fifo_status_t;

  // counts clocks inside one serial bit, must reach UART_CLKS_PER_BIT
  typedef logic [$clog2(`UART_CLKS_PER_BIT + 1)-1:0] baud_cnt_t;

  // index of the data bit on the line
  typedef logic [2:0] bit_idx_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage

// File: design/sync_fifo.sv
module sync_fifo #(
  parameter int ADDR_WIDTH = 3,
  parameter int DATA_WIDTH = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        w_inc,
  input  logic [DATA_WIDTH-1:0]       w_data,
  input  logic                        r_inc,
  output logic [DATA_WIDTH-1:0]       r_data,
  output uart_link_pkg::fifo_status_t status
);

  localparam int DEPTH = 1 << ADDR_WIDTH;
  localparam logic [ADDR_WIDTH:0] HALF_DEPTH = (ADDR_WIDTH + 1)'(DEPTH >> 1);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // pointers carry one extra bit to tell full from empty
  logic [ADDR_WIDTH:0]   w_ptr;
  logic [ADDR_WIDTH:0]   r_ptr;
  logic [ADDR_WIDTH:0]   used;
  logic [ADDR_WIDTH-1:0] w_addr;
  logic [ADDR_WIDTH-1:0] r_addr;
  logic                  full;
  logic                  empty;
  logic                  do_write;
  logic                  do_read;

  assign w_addr = w_ptr[ADDR_WIDTH-1:0];
  assign r_addr = r_ptr[ADDR_WIDTH-1:0];

  // strobes against the flags are dropped here
  assign do_write = w_inc && !full;
  assign do_read  = r_inc && !empty;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[w_addr] <= w_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (do_write) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (do_read) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

  assign used  = w_ptr - r_ptr;
  assign full  = (w_ptr[ADDR_WIDTH] != r_ptr[ADDR_WIDTH]) && (w_addr == r_addr);
  assign empty = (w_ptr == r_ptr);

  // first word falls through, no read latency
  assign r_data = mem[r_addr];

  assign status = '{full: full, half_full: (used >= HALF_DEPTH), empty: empty};

endmodule

// File: design/uart_tx.sv
`include "uart_link_macros.svh"

module uart_tx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fifo_empty,
  input  uart_link_pkg::byte_t fifo_data,
  output logic                 fifo_rd,
  output logic                 txd
);

  import uart_link_pkg::*;

  localparam baud_cnt_t BIT_LAST = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);

  tx_state_t state;
  baud_cnt_t baud_cnt;
  bit_idx_t  bit_idx;
  byte_t     shift_q;
  logic      bit_done;

  assign bit_done = (baud_cnt == BIT_LAST);

  // pop when idle, or straight out of the stop bit so frames run back to back
  assign fifo_rd = !fifo_empty &&
                   ((state == TX_IDLE) || ((state == TX_STOP) && bit_done));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= TX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      txd      <= 1'b1;
    end else if (fifo_rd) begin
      // start bit goes out on the next cycle
      state    <= TX_START;
      baud_cnt <= '0;
      txd      <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          txd <= 1'b1;
        end
        TX_START: begin
          baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
          if (bit_done) begin
            state   <= TX_DATA;
            bit_idx <= '0;
            txd     <= shift_q[0];
          end
        end
        TX_DATA: begin
          baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
          if (bit_done) begin
            if (bit_idx == 3'd7) begin
              state <= TX_STOP;
              txd   <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              txd     <= shift_q[1];
            end
          end
        end
        default: begin
          baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
          if (bit_done) begin
            state <= TX_IDLE;
          end
        end
      endcase
    end
  end

  // lsb first, the next bit always sits in shift_q[1]
  always_ff @(posedge clk) begin
    if (fifo_rd) begin
      shift_q <= fifo_data;
    end else if ((state == TX_DATA) && bit_done) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

// File: design/uart_rx.sv
`include "uart_link_macros.svh"

module uart_rx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rxd,
  input  logic                 fifo_full,
  output logic                 fifo_wr,
  output uart_link_pkg::byte_t fifo_data,
  output logic                 frame_err,
  output logic                 overrun
);

  import uart_link_pkg::*;

  localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
  localparam baud_cnt_t HALF_LAST = baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1);

  logic      rxd_meta;
  logic      rxd_s;
  logic      armed;
  rx_state_t state;
  baud_cnt_t baud_cnt;
  bit_idx_t  bit_idx;
  logic      bit_done;

  // two flop synchronizer, idles high like the line
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rxd_meta <= 1'b1;
      rxd_s    <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_s    <= rxd_meta;
    end
  end

  assign bit_done = (baud_cnt == ((state == RX_START) ? HALF_LAST : BIT_LAST));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= RX_IDLE;
      armed     <= 1'b0;
      baud_cnt  <= '0;
      bit_idx   <= '0;
      fifo_wr   <= 1'b0;
      frame_err <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      fifo_wr   <= 1'b0;
      frame_err <= 1'b0;
      overrun   <= 1'b0;
      baud_cnt  <= bit_done ? '0 : baud_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          // a start edge only counts once the line was seen high
          if (rxd_s) begin
            armed <= 1'b1;
          end else if (armed) begin
            armed <= 1'b0;
            state <= RX_START;
          end
        end
        RX_START: begin
          if (bit_done) begin
            // glitch, not a real start bit
            state   <= rxd_s ? RX_IDLE : RX_DATA;
            bit_idx <= '0;
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        default: begin
          if (bit_done) begin
            state     <= RX_IDLE;
            fifo_wr   <= rxd_s && !fifo_full;
            overrun   <= rxd_s && fifo_full;
            frame_err <= !rxd_s;
          end
        end
      endcase
    end
  end

  // mid-bit samples enter at the top, lsb ends up at bit 0
  always_ff @(posedge clk) begin
    if ((state == RX_DATA) && bit_done) begin
      fifo_data <= {rxd_s, fifo_data[`LINK_DATA_W-1:1]};
    end
  end

endmodule

// File: design/uart_fifo_link.sv
`include "uart_link_macros.svh"

module uart_fifo_link (
  input  logic                        clk,
  input  logic                        rst_n,
  // host transmit side
  input  logic                        tx_wr,
  input  uart_link_pkg::byte_t        tx_data,
  output uart_link_pkg::fifo_status_t tx_status,
  // host receive side
  input  logic                        rx_rd,
  output uart_link_pkg::byte_t        rx_data,
  output uart_link_pkg::fifo_status_t rx_status,
  // serial line
  output logic                        txd,
  input  logic                        rxd,
  output logic                        frame_err,
  output logic                        overrun
);

  import uart_link_pkg::*;

  byte_t tx_head;
  logic  tx_pop;
  byte_t rx_byte;
  logic  rx_push;

  sync_fifo #(
    .ADDR_WIDTH(`LINK_FIFO_AW),
    .DATA_WIDTH(`LINK_DATA_W)
  ) u_tx_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .w_inc (tx_wr),
    .w_data(tx_data),
    .r_inc (tx_pop),
    .r_data(tx_head),
    .status(tx_status)
  );

  uart_tx u_uart_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .fifo_empty(tx_status.empty),
    .fifo_data (tx_head),
    .fifo_rd   (tx_pop),
    .txd       (txd)
  );

  // overrun is raised by the receiver from the fifo full flag
  uart_rx u_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rxd      (rxd),
    .fifo_full(rx_status.full),
    .fifo_wr  (rx_push),
    .fifo_data(rx_byte),
    .frame_err(frame_err),
    .overrun  (overrun)
  );

  sync_fifo #(
    .ADDR_WIDTH(`LINK_FIFO_AW),
    .DATA_WIDTH(`LINK_DATA_W)
  ) u_rx_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .w_inc (rx_push),
    .w_data(rx_byte),
    .r_inc (rx_rd),
    .r_data(rx_data),
    .status(rx_status)
  );

endmodule

// File: tb/uart_fifo_link_chk.sv
module uart_fifo_link_chk (
  input logic                        clk,
  input logic                        rst_n,
  input uart_link_pkg::fifo_status_t tx_status,
  input uart_link_pkg::fifo_status_t rx_status,
  input uart_link_pkg::tx_state_t    tx_state,
  input logic                        txd,
  input logic                        frame_err,
  input logic                        overrun,
  input logic                        rx_push
);

  import uart_link_pkg::*;

  int fail_cnt = 0;

  a_flags: assert property (@(posedge clk) disable iff (!rst_n)
    !(tx_status.full && tx_status.empty) && !(rx_status.full && rx_status.empty))
    else begin
      fail_cnt++;
      $error("a fifo reports full and empty at once");
    end

  // line idles high out of reset
  a_reset_txd: assert property (@(posedge clk) !rst_n |=> txd)
    else begin
      fail_cnt++;
      $error("txd is not high after reset");
    end

  a_idle_txd: assert property (@(posedge clk) disable iff (!rst_n) (tx_state == TX_IDLE) |-> txd)
    else begin
      fail_cnt++;
      $error("txd is low while the transmitter is idle");
    end

  a_frame_err_pulse: assert property (@(posedge clk) disable iff (!rst_n) frame_err |=> !frame_err)
    else begin
      fail_cnt++;
      $error("frame_err is held longer than one cycle");
    end

  a_overrun_pulse: assert property (@(posedge clk) disable iff (!rst_n) overrun |=> !overrun)
    else begin
      fail_cnt++;
      $error("overrun is held longer than one cycle");
    end

  a_push_not_full: assert property (@(posedge clk) disable iff (!rst_n) rx_push |-> !rx_status.full)
    else begin
      fail_cnt++;
      $error("the receiver pushed into a full rx fifo");
    end

endmodule

bind uart_fifo_link uart_fifo_link_chk u_chk (.*, .tx_state(u_uart_tx.state));

// File: tb/tb_uart_fifo_link.sv
`include "uart_link_macros.svh"

module tb_uart_fifo_link;

  import uart_link_pkg::*;

  localparam int DEPTH         = 1 << `LINK_FIFO_AW;
  localparam int FRAME_CYCLES  = `UART_FRAME_BITS * `UART_CLKS_PER_BIT;
  localparam int WAIT_DRAIN    = 0;
  localparam int WAIT_TX_EMPTY = 1;
  localparam int WAIT_OVERRUN  = 2;

  logic         clk;
  logic         rst_n;
  logic         tx_wr;
  byte_t        tx_data;
  fifo_status_t tx_status;
  logic         rx_rd;
  byte_t        rx_data;
  fifo_status_t rx_status;
  logic         txd;
  logic         rxd;
  logic         frame_err;
  logic         overrun;
  logic         man_rxd;
  logic         loopback;
  logic         auto_read;
  byte_t        exp_q[$];
  int           errors;
  int           ovr_cnt;
  int           fe_cnt;
  int           seed;

  // loopback switch
  assign rxd = loopback ? txd : man_rxd;

  uart_fifo_link i_uart_fifo_link (.*);

  always #5 clk = ~clk;

  task automatic expect_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      errors++;
      $display("ERROR at %0t: %s expected %0h got %0h", $time, what, exp, act);
    end
  endtask

  // scoreboard, host reader and pulse counters
  always @(posedge clk) begin
    if (rx_rd && !rx_status.empty) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR at %0t: byte %0h read with nothing expected", $time, rx_data);
      end else begin
        expect_equal("rx_data", exp_q.pop_front(), rx_data);
      end
    end
    if (rst_n && tx_wr && !tx_status.full) begin
      exp_q.push_back(tx_data);
    end
    if (overrun) begin
      ovr_cnt++;
    end
    if (frame_err) begin
      fe_cnt++;
    end
    rx_rd <= auto_read && !rx_status.empty;
  end

  task automatic write_byte(input byte_t b);
    @(posedge clk);
    tx_wr   <= 1'b1;
    tx_data <= b;
    @(posedge clk);
    tx_wr <= 1'b0;
    @(negedge clk);
  endtask

  // start bit, lsb first data, chosen stop bit, then two idle bits
  task automatic send_frame(input byte_t b, input logic stop);
    logic [9:0] bits;
    bits = {stop, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      man_rxd <= bits[i];
      repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk);
    end
    @(posedge clk);
    man_rxd <= 1'b1;
    repeat (2 * `UART_CLKS_PER_BIT) @(posedge clk);
    @(negedge clk);
  endtask

  function automatic logic cond_met(input int kind);
    case (kind)
      WAIT_DRAIN:    return exp_q.size() == 0;
      WAIT_TX_EMPTY: return tx_status.empty;
      default:       return ovr_cnt != 0;
    endcase
  endfunction

  task automatic wait_for(input int kind, input int limit, input string what);
    int n;
    n = 0;
    while (!cond_met(kind) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!cond_met(kind)) begin
      errors++;
      $display("timeout after %0d cycles while waiting for %s", limit, what);
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    tx_wr     = 1'b0;
    tx_data   = '0;
    rx_rd     = 1'b0;
    man_rxd   = 1'b1;
    loopback  = 1'b1;
    auto_read = 1'b1;
    errors    = 0;
    ovr_cnt   = 0;
    fe_cnt    = 0;
    seed      = 32'h9ade;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    expect_equal("tx_status after reset", 3'b001, tx_status);
    expect_equal("rx_status after reset", 3'b001, rx_status);
    expect_equal("txd after reset", 1, txd);
    expect_equal("error pulses after reset", 0, {frame_err, overrun});

    // loopback with the host reading as bytes show up
    repeat (6) write_byte(byte_t'($random(seed)));
    wait_for(WAIT_DRAIN, 8 * FRAME_CYCLES, "loopback bytes to come back");

    // host stops reading while the first byte keeps the transmitter busy
    auto_read = 1'b0;
    write_byte(byte_t'($random(seed)));
    wait_for(WAIT_TX_EMPTY, FRAME_CYCLES, "the first byte to leave the tx fifo");
    for (int i = 1; i <= DEPTH; i++) begin
      write_byte(byte_t'($random(seed)));
      expect_equal("tx half_full", i >= DEPTH / 2, tx_status.half_full);
      expect_equal("tx full", i == DEPTH, tx_status.full);
    end
    // written while full so it never reaches the scoreboard
    write_byte(byte_t'($random(seed)));
    expect_equal("tx full after ignored write", 1, tx_status.full);
    wait_for(WAIT_OVERRUN, (DEPTH + 3) * FRAME_CYCLES, "an overrun pulse");
    expect_equal("rx full at overrun", 1, rx_status.full);
    // the ninth received byte was dropped by the rx side
    void'(exp_q.pop_back());
    auto_read = 1'b1;
    wait_for(WAIT_DRAIN, FRAME_CYCLES, "the rx fifo to drain");
    expect_equal("overrun pulses", 1, ovr_cnt);

    // manual frames with a bad stop bit first, host holds off reading
    auto_read = 1'b0;
    @(posedge clk);
    loopback <= 1'b0;
    send_frame(8'h5a, 1'b0);
    expect_equal("frame_err pulses", 1, fe_cnt);
    expect_equal("rx empty after bad frame", 1, rx_status.empty);
    auto_read = 1'b1;
    exp_q.push_back(8'hc3);
    send_frame(8'hc3, 1'b1);
    wait_for(WAIT_DRAIN, FRAME_CYCLES, "the good frame after the framing error");
    expect_equal("frame_err pulses after good frame", 1, fe_cnt);

    $display("errors: %0d, assertion failures: %0d", errors, i_uart_fifo_link.u_chk.fail_cnt);
    if (errors == 0 && i_uart_fifo_link.u_chk.fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
design/uart_link_pkg.sv
design/sync_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_fifo_link.sv
tb/uart_fifo_link_chk.sv
tb/tb_uart_fifo_link.sv
